//--- cm_pkg.sv
package cm_pkg;

    // Record and header sizes in bytes
    localparam int QP_INFO_BYTES = 64;
    localparam int UDP_HDR_BYTES = 8;

    // Field types
    typedef logic [23:0]  qpn_t;
    typedef logic [23:0]  psn_t;
    typedef logic [31:0]  rkey_t;
    typedef logic [63:0]  vaddr_t;
    typedef logic [31:0]  ipv4_t;
    typedef logic [15:0]  udp_port_t;
    typedef logic [15:0]  udp_len_t;
    typedef logic [QP_INFO_BYTES*8-1:0] qp_record_t;

    // Byte offsets of the fields inside the 64-byte record
    localparam int OFS_QP_FLAGS      = 0;
    localparam int OFS_LOC_QPN       = 1;
    localparam int OFS_LOC_PSN       = 5;
    localparam int OFS_LOC_RKEY      = 9;
    localparam int OFS_LOC_BASE_ADDR = 13;
    localparam int OFS_LOC_IP        = 21;
    localparam int OFS_REM_QPN       = 25;
    localparam int OFS_REM_PSN       = 29;
    localparam int OFS_REM_RKEY      = 33;
    localparam int OFS_REM_BASE_ADDR = 37;
    localparam int OFS_REM_IP        = 45;
    localparam int OFS_LISTEN_PORT   = 49;
    localparam int OFS_TX_FLAGS      = 51;
    localparam int OFS_DMA_LENGTH    = 52;
    localparam int OFS_N_TRANSFERS   = 56;
    localparam int OFS_FREQUENCY     = 60;

    // Bit positions inside the QP flag byte
    localparam int QPF_INFO_VALID = 0;
    localparam int QPF_REQ_TYPE   = 1;
    localparam int QPF_ACK_VALID  = 4;
    localparam int QPF_ACK_TYPE   = 5;

    // Bit positions inside the transmit flag byte
    localparam int TXF_META_VALID   = 0;
    localparam int TXF_START        = 1;
    localparam int TXF_IS_IMMEDIATE = 2;
    localparam int TXF_TX_TYPE      = 3;

    // Queue-pair information as held at the outputs
    typedef struct packed {
        logic [2:0] req_type;
        logic [2:0] ack_type;
        qpn_t       loc_qpn;
        psn_t       loc_psn;
        rkey_t      loc_rkey;
        vaddr_t     loc_base_addr;
        ipv4_t      loc_ip;
        qpn_t       rem_qpn;
        psn_t       rem_psn;
        rkey_t      rem_rkey;
        vaddr_t     rem_base_addr;
        ipv4_t      rem_ip;
        udp_port_t  listen_port;
    } qp_info_t;

    // Transmit metadata, tx_type is 0 for SEND and 1 for RDMA WRITE
    typedef struct packed {
        logic        start;
        logic        is_immediate;
        logic        tx_type;
        qpn_t        loc_qpn;
        logic [31:0] dma_length;
        logic [31:0] n_transfers;
        logic [31:0] frequency;
    } txmeta_t;

    // Filter states
    typedef enum logic [1:0] {
        IDLE,
        ACCEPT,
        DISCARD
    } filt_state_t;

endpackage

//--- udp_hdr_filter.sv
`timescale 1ns/1ps

module udp_hdr_filter
    import cm_pkg::*;
#(
    parameter int        DATA_WIDTH  = 256,
    parameter udp_port_t LISTEN_PORT = 16'h4321
) (
    input  logic                  clk,
    input  logic                  rst,

    // UDP header
    input  logic                  hdr_valid,
    output logic                  hdr_ready,
    input  udp_port_t             dest_port,
    input  udp_len_t              length,

    // UDP payload
    input  logic                  tvalid,
    output logic                  tready,
    input  logic [DATA_WIDTH-1:0] tdata,
    input  logic                  tlast,

    // Accepted beats towards the assembler
    output logic                  beat_valid,
    output logic [DATA_WIDTH-1:0] beat_data,
    output logic                  beat_last,

    output logic                  busy
);

    // Only a full connection record is worth decoding
    localparam udp_len_t FRAME_LEN = udp_len_t'(QP_INFO_BYTES + UDP_HDR_BYTES);

    filt_state_t state;
    filt_state_t state_next;

    logic hdr_xfer;
    logic hdr_match;
    logic pay_xfer;

    assign hdr_xfer  = hdr_valid && hdr_ready;
    assign hdr_match = (dest_port == LISTEN_PORT) && (length == FRAME_LEN);
    assign pay_xfer  = tvalid && tready;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_xfer) begin
                    state_next = hdr_match ? ACCEPT : DISCARD;
                end
            end
            ACCEPT, DISCARD: begin
                // Frame ends on the beat carrying tlast
                if (pay_xfer && tlast) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Handshakes follow the state directly
    assign hdr_ready = (state == IDLE);
    assign tready    = (state == ACCEPT) || (state == DISCARD);
    assign busy      = (state != IDLE);

    // Beats of a rejected frame are swallowed here
    assign beat_valid = pay_xfer && (state == ACCEPT);
    assign beat_data  = tdata;
    assign beat_last  = tlast;

endmodule

//--- record_assembler.sv
`timescale 1ns/1ps

module record_assembler
    import cm_pkg::*;
#(
    parameter int DATA_WIDTH = 256
) (
    input  logic                  clk,
    input  logic                  rst,

    // Accepted payload beats
    input  logic                  beat_valid,
    input  logic [DATA_WIDTH-1:0] beat_data,
    input  logic                  beat_last,

    // Complete record
    output logic                  rec_valid,
    output qp_record_t            rec
);

    // Beats per record and counter sizing
    localparam int BEATS = QP_INFO_BYTES / (DATA_WIDTH / 8);
    localparam int CNT_W = $clog2(BEATS + 2);

    // Index of the final beat, and the saturation value for overlong frames
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(BEATS - 1);
    localparam logic [CNT_W-1:0] OVERRUN  = CNT_W'(BEATS);

    logic [CNT_W-1:0] cnt;
    logic             count_ok;

    // Last beat lands in the final slot only for a frame of the right size
    assign count_ok = (cnt == LAST_IDX);

    // Beat counter and record pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            if (beat_valid) begin
                if (beat_last) begin
                    cnt       <= '0;
                    rec_valid <= count_ok;
                end else if (cnt != OVERRUN) begin
                    // Sticks at OVERRUN so a long frame never matches
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // Record storage, one slot per beat
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            for (int i = 0; i < BEATS; i++) begin
                if (cnt == CNT_W'(i)) begin
                    rec[i*DATA_WIDTH +: DATA_WIDTH] <= beat_data;
                end
            end
        end
    end

endmodule

//--- qp_record_decoder.sv
`timescale 1ns/1ps

module qp_record_decoder
    import cm_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Record from the assembler
    input  logic       rec_valid,
    input  qp_record_t rec,

    // Queue-pair information
    output logic       qp_info_valid,
    output logic       ack_valid,
    output qp_info_t   qp_info,

    // Transmit metadata
    output logic       metadata_valid,
    output logic       start_transfer,
    output txmeta_t    txmeta
);

    logic [7:0] qp_flags;
    logic [7:0] tx_flags;
    logic       info_flag;
    logic       ack_flag;
    logic       meta_flag;
    logic       ack_flag_q;

    qp_info_t   qp_dec;
    txmeta_t    tx_dec;

    // Flag bytes
    assign qp_flags  = rec[OFS_QP_FLAGS*8 +: 8];
    assign tx_flags  = rec[OFS_TX_FLAGS*8 +: 8];
    assign info_flag = qp_flags[QPF_INFO_VALID];
    assign ack_flag  = qp_flags[QPF_ACK_VALID];
    assign meta_flag = tx_flags[TXF_META_VALID];

    // Little-endian fields at their byte offsets
    assign qp_dec.req_type      = qp_flags[QPF_REQ_TYPE +: 3];
    assign qp_dec.ack_type      = qp_flags[QPF_ACK_TYPE +: 3];
    assign qp_dec.loc_qpn       = rec[OFS_LOC_QPN*8       +: $bits(qpn_t)];
    assign qp_dec.loc_psn       = rec[OFS_LOC_PSN*8       +: $bits(psn_t)];
    assign qp_dec.loc_rkey      = rec[OFS_LOC_RKEY*8      +: $bits(rkey_t)];
    assign qp_dec.loc_base_addr = rec[OFS_LOC_BASE_ADDR*8 +: $bits(vaddr_t)];
    assign qp_dec.loc_ip        = rec[OFS_LOC_IP*8        +: $bits(ipv4_t)];
    assign qp_dec.rem_qpn       = rec[OFS_REM_QPN*8       +: $bits(qpn_t)];
    assign qp_dec.rem_psn       = rec[OFS_REM_PSN*8       +: $bits(psn_t)];
    assign qp_dec.rem_rkey      = rec[OFS_REM_RKEY*8      +: $bits(rkey_t)];
    assign qp_dec.rem_base_addr = rec[OFS_REM_BASE_ADDR*8 +: $bits(vaddr_t)];
    assign qp_dec.rem_ip        = rec[OFS_REM_IP*8        +: $bits(ipv4_t)];
    assign qp_dec.listen_port   = rec[OFS_LISTEN_PORT*8   +: $bits(udp_port_t)];

    assign tx_dec.start        = tx_flags[TXF_START];
    assign tx_dec.is_immediate = tx_flags[TXF_IS_IMMEDIATE];
    assign tx_dec.tx_type      = tx_flags[TXF_TX_TYPE];
    // Transfers target the remote queue pair
    assign tx_dec.loc_qpn      = qp_dec.rem_qpn;
    assign tx_dec.dma_length   = rec[OFS_DMA_LENGTH*8  +: 32];
    assign tx_dec.n_transfers  = rec[OFS_N_TRANSFERS*8 +: 32];
    assign tx_dec.frequency    = rec[OFS_FREQUENCY*8   +: 32];

    // Pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            qp_info_valid  <= 1'b0;
            metadata_valid <= 1'b0;
            ack_flag_q     <= 1'b0;
        end else begin
            qp_info_valid  <= rec_valid && info_flag;
            metadata_valid <= rec_valid && meta_flag;
            ack_flag_q     <= rec_valid && ack_flag;
        end
    end

    // Held fields, each group refreshed only when its flag is set
    always_ff @(posedge clk) begin
        if (rec_valid && info_flag) begin
            qp_info.req_type      <= qp_dec.req_type;
            qp_info.loc_qpn       <= qp_dec.loc_qpn;
            qp_info.loc_psn       <= qp_dec.loc_psn;
            qp_info.loc_rkey      <= qp_dec.loc_rkey;
            qp_info.loc_base_addr <= qp_dec.loc_base_addr;
            qp_info.loc_ip        <= qp_dec.loc_ip;
            qp_info.rem_qpn       <= qp_dec.rem_qpn;
            qp_info.rem_psn       <= qp_dec.rem_psn;
            qp_info.rem_rkey      <= qp_dec.rem_rkey;
            qp_info.rem_base_addr <= qp_dec.rem_base_addr;
            qp_info.rem_ip        <= qp_dec.rem_ip;
            qp_info.listen_port   <= qp_dec.listen_port;
        end
        if (rec_valid && ack_flag) begin
            qp_info.ack_type <= qp_dec.ack_type;
        end
        if (rec_valid && meta_flag) begin
            txmeta <= tx_dec;
        end
    end

    assign ack_valid      = ack_flag_q && qp_info_valid;
    assign start_transfer = txmeta.start && metadata_valid;

endmodule

//--- cm_rx_top.sv
`timescale 1ns/1ps

module cm_rx_top
    import cm_pkg::*;
#(
    parameter int        DATA_WIDTH  = 256,
    parameter udp_port_t LISTEN_PORT = 16'h4321
) (
    input  logic                  clk,
    input  logic                  rst,

    // UDP header
    input  logic                  hdr_valid,
    output logic                  hdr_ready,
    input  udp_port_t             dest_port,
    input  udp_len_t              length,

    // UDP payload
    input  logic                  tvalid,
    output logic                  tready,
    input  logic [DATA_WIDTH-1:0] tdata,
    input  logic                  tlast,

    // Queue-pair information
    output logic                  qp_info_valid,
    output logic                  ack_valid,
    output qp_info_t              qp_info,

    // Transmit metadata
    output logic                  metadata_valid,
    output logic                  start_transfer,
    output txmeta_t               txmeta,

    output logic                  busy
);

    logic                  beat_valid;
    logic [DATA_WIDTH-1:0] beat_data;
    logic                  beat_last;
    logic                  rec_valid;
    qp_record_t            rec;

    // Header check and payload steering
    udp_hdr_filter #(
        .DATA_WIDTH  (DATA_WIDTH),
        .LISTEN_PORT (LISTEN_PORT)
    ) udp_hdr_filter_i (
        .clk        (clk),
        .rst        (rst),
        .hdr_valid  (hdr_valid),
        .hdr_ready  (hdr_ready),
        .dest_port  (dest_port),
        .length     (length),
        .tvalid     (tvalid),
        .tready     (tready),
        .tdata      (tdata),
        .tlast      (tlast),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_last  (beat_last),
        .busy       (busy)
    );

    // Beats into one 512-bit record
    record_assembler #(
        .DATA_WIDTH (DATA_WIDTH)
    ) record_assembler_i (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_last  (beat_last),
        .rec_valid  (rec_valid),
        .rec        (rec)
    );

    // Record into QP info and transmit metadata
    qp_record_decoder qp_record_decoder_i (
        .clk            (clk),
        .rst            (rst),
        .rec_valid      (rec_valid),
        .rec            (rec),
        .qp_info_valid  (qp_info_valid),
        .ack_valid      (ack_valid),
        .qp_info        (qp_info),
        .metadata_valid (metadata_valid),
        .start_transfer (start_transfer),
        .txmeta         (txmeta)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

//--- cm_rx_tb.sv
`timescale 1ns/1ps

module cm_rx_tb
    import cm_pkg::*;
();

    localparam int        DATA_WIDTH    = 256;
    localparam udp_port_t LISTEN_PORT   = 16'h4321;
    localparam int        BPB           = DATA_WIDTH / 8;
    localparam int        BEATS         = 64 / BPB;
    localparam int        NUM_FRAMES    = 24;
    localparam int        MAX_GAP       = 2;
    localparam int        CLK_PERIOD_NS = 100;
    localparam int        WATCHDOG_NS   =
        (NUM_FRAMES * (BEATS * (MAX_GAP + 1) + 10) + 10) * CLK_PERIOD_NS;

    // One expected output event for each decoded frame that pulses
    typedef struct packed {
        logic     info_p;
        logic     meta_p;
        logic     ack;
        logic     start;
        qp_info_t info;
        txmeta_t  tx;
    } exp_t;

    logic                  clk;
    logic                  rst;
    logic                  hdr_valid;
    logic                  hdr_ready;
    udp_port_t             dest_port;
    udp_len_t              length;
    logic                  tvalid;
    logic                  tready;
    logic [DATA_WIDTH-1:0] tdata;
    logic                  tlast;
    logic                  qp_info_valid;
    logic                  ack_valid;
    qp_info_t              qp_info;
    logic                  metadata_valid;
    logic                  start_transfer;
    txmeta_t               txmeta;
    logic                  busy;

    logic [31:0] rng_state;
    logic [7:0]  rec_bytes [64];
    qp_info_t    model_info;
    txmeta_t     model_tx;
    exp_t        exp_q [$];
    int          exp_n_info;
    int          exp_n_meta;
    int          n_info;
    int          n_meta;
    logic        exp_busy;

    tb_clock #(
        .PERIOD_NS (CLK_PERIOD_NS)
    ) tb_clock_i (
        .clk (clk)
    );

    cm_rx_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .LISTEN_PORT (LISTEN_PORT)
    ) cm_rx_top_i (
        .clk            (clk),
        .rst            (rst),
        .hdr_valid      (hdr_valid),
        .hdr_ready      (hdr_ready),
        .dest_port      (dest_port),
        .length         (length),
        .tvalid         (tvalid),
        .tready         (tready),
        .tdata          (tdata),
        .tlast          (tlast),
        .qp_info_valid  (qp_info_valid),
        .ack_valid      (ack_valid),
        .qp_info        (qp_info),
        .metadata_valid (metadata_valid),
        .start_transfer (start_transfer),
        .txmeta         (txmeta),
        .busy           (busy)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Little-endian field of n bytes starting at byte ofs
    function automatic logic [63:0] le_bytes(input logic [7:0] rb [64], input int ofs,
                                             input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[k*8 +: 8] = rb[ofs + k];
        end
        return v;
    endfunction

    // Expected decode of one record by its byte layout
    function automatic void ref_decode(input logic [7:0] rb [64], output qp_info_t info,
                                       output txmeta_t tx);
        info.req_type      = rb[0][3:1];
        info.ack_type      = rb[0][7:5];
        info.loc_qpn       = qpn_t'(le_bytes(rb, 1, 3));
        info.loc_psn       = psn_t'(le_bytes(rb, 5, 3));
        info.loc_rkey      = rkey_t'(le_bytes(rb, 9, 4));
        info.loc_base_addr = le_bytes(rb, 13, 8);
        info.loc_ip        = ipv4_t'(le_bytes(rb, 21, 4));
        info.rem_qpn       = qpn_t'(le_bytes(rb, 25, 3));
        info.rem_psn       = psn_t'(le_bytes(rb, 29, 3));
        info.rem_rkey      = rkey_t'(le_bytes(rb, 33, 4));
        info.rem_base_addr = le_bytes(rb, 37, 8);
        info.rem_ip        = ipv4_t'(le_bytes(rb, 45, 4));
        info.listen_port   = udp_port_t'(le_bytes(rb, 49, 2));
        tx.start           = rb[51][1];
        tx.is_immediate    = rb[51][2];
        tx.tx_type         = rb[51][3];
        tx.loc_qpn         = info.rem_qpn;
        tx.dma_length      = 32'(le_bytes(rb, 52, 4));
        tx.n_transfers     = 32'(le_bytes(rb, 56, 4));
        tx.frequency       = 32'(le_bytes(rb, 60, 4));
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [511:0] got,
                                   input logic [511:0] exp);
        $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Apply the update rules of a kept frame to the model and queue its pulses
    task automatic expect_frame();
        qp_info_t   dec_info;
        txmeta_t    dec_tx;
        exp_t       e;
        logic [2:0] held_ack;
        ref_decode(rec_bytes, dec_info, dec_tx);
        // ack_type follows its own flag
        held_ack = model_info.ack_type;
        if (rec_bytes[0][0]) begin
            model_info          = dec_info;
            model_info.ack_type = held_ack;
            exp_n_info++;
        end
        if (rec_bytes[0][4]) begin
            model_info.ack_type = dec_info.ack_type;
        end
        if (rec_bytes[51][0]) begin
            model_tx = dec_tx;
            exp_n_meta++;
        end
        if (rec_bytes[0][0] || rec_bytes[51][0]) begin
            e.info_p = rec_bytes[0][0];
            e.meta_p = rec_bytes[51][0];
            e.ack    = rec_bytes[0][4];
            e.start  = rec_bytes[51][1];
            e.info   = model_info;
            e.tx     = model_tx;
            exp_q.push_back(e);
        end
    endtask

    task automatic send_header(input udp_port_t port, input udp_len_t len);
        logic acc;
        hdr_valid <= 1'b1;
        dest_port <= port;
        length    <= len;
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = hdr_ready;
            @(posedge clk);
        end
        hdr_valid <= 1'b0;
    endtask

    task automatic send_payload();
        logic [DATA_WIDTH-1:0] d;
        logic                  acc;
        int                    gap;
        for (int b = 0; b < BEATS; b++) begin
            gap = int'(next_rand() % 32'(MAX_GAP + 1));
            repeat (gap) begin
                tvalid <= 1'b0;
                @(posedge clk);
            end
            for (int j = 0; j < BPB; j++) begin
                d[j*8 +: 8] = rec_bytes[b*BPB + j];
            end
            tvalid <= 1'b1;
            tdata  <= d;
            tlast  <= (b == BEATS - 1);
            acc = 1'b0;
            while (!acc) begin
                @(negedge clk);
                acc = tready;
                @(posedge clk);
            end
        end
        tvalid <= 1'b0;
        tlast  <= 1'b0;
    endtask

    // Stimulus
    initial begin
        udp_port_t port;
        udp_len_t  len;
        rst        <= 1'b1;
        hdr_valid  <= 1'b0;
        dest_port  <= '0;
        length     <= '0;
        tvalid     <= 1'b0;
        tdata      <= '0;
        tlast      <= 1'b0;
        rng_state  = 32'haf85_316d;
        exp_n_info = 0;
        exp_n_meta = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int i = 0; i < 64; i++) begin
                rec_bytes[i] = 8'(next_rand());
            end
            port = LISTEN_PORT;
            len  = 16'd72;
            case (f % 6)
                0: begin
                    // First record sets every group so all held outputs are known
                    if (f == 0) begin
                        rec_bytes[0]  = rec_bytes[0] | 8'h11;
                        rec_bytes[51] = rec_bytes[51] | 8'h01;
                    end
                end
                1: port = LISTEN_PORT + 16'd1 + udp_port_t'(next_rand() % 32'd200);
                3: len = 16'd73 + udp_len_t'(next_rand() % 32'd64);
                4: begin
                    rec_bytes[0][0]  = 1'b0;
                    rec_bytes[51][0] = 1'b1;
                end
                5: begin
                    rec_bytes[0][0]  = 1'b1;
                    rec_bytes[51][0] = 1'b0;
                end
                default: begin
                end
            endcase
            if (port == LISTEN_PORT && len == 16'd72) begin
                expect_frame();
            end
            send_header(port, len);
            send_payload();
        end
        // Decoder pulses trail the last beat by two cycles
        repeat (4) @(posedge clk);
        assert (n_info == exp_n_info)
            else fail_run($sformatf("Saw %0d info pulses but expected %0d", n_info, exp_n_info));
        assert (n_meta == exp_n_meta)
            else fail_run($sformatf("Saw %0d metadata pulses but expected %0d", n_meta,
                                    exp_n_meta));
        assert (qp_info === model_info)
            else report_mismatch("qp_info", 512'(qp_info), 512'(model_info));
        assert (txmeta === model_tx)
            else report_mismatch("txmeta", 512'(txmeta), 512'(model_tx));
        $display("Simulation completed successfully");
        $finish;
    end

    // Comparator samples between edges
    initial begin
        n_info = 0;
        n_meta = 0;
    end

    always @(negedge clk) begin
        exp_t e;
        if (rst !== 1'b0) begin
            exp_busy = 1'b0;
        end else begin
            assert (busy === exp_busy)
                else report_mismatch("busy", 512'(busy), 512'(exp_busy));
            assert (tready === exp_busy)
                else report_mismatch("tready", 512'(tready), 512'(exp_busy));
            assert (hdr_ready === !exp_busy)
                else report_mismatch("hdr_ready", 512'(hdr_ready), 512'(!exp_busy));
            // Filter state for the coming edge
            if (hdr_valid && !exp_busy) begin
                exp_busy = 1'b1;
            end else if (tvalid && exp_busy && tlast) begin
                exp_busy = 1'b0;
            end
            if (qp_info_valid === 1'b1 || metadata_valid === 1'b1) begin
                assert (exp_q.size() > 0)
                    else fail_run("Output pulse arrived with no decoded frame pending");
                e = exp_q.pop_front();
                if (qp_info_valid) begin
                    n_info++;
                end
                if (metadata_valid) begin
                    n_meta++;
                end
                assert (qp_info_valid === e.info_p)
                    else report_mismatch("qp_info_valid", 512'(qp_info_valid), 512'(e.info_p));
                assert (metadata_valid === e.meta_p)
                    else report_mismatch("metadata_valid", 512'(metadata_valid),
                                         512'(e.meta_p));
                assert (ack_valid === (e.info_p & e.ack))
                    else report_mismatch("ack_valid", 512'(ack_valid), 512'(e.info_p & e.ack));
                assert (start_transfer === (e.meta_p & e.start))
                    else report_mismatch("start_transfer", 512'(start_transfer),
                                         512'(e.meta_p & e.start));
                assert (qp_info === e.info)
                    else report_mismatch("qp_info", 512'(qp_info), 512'(e.info));
                assert (txmeta === e.tx)
                    else report_mismatch("txmeta", 512'(txmeta), 512'(e.tx));
            end else begin
                assert (ack_valid === 1'b0)
                    else report_mismatch("ack_valid", 512'(ack_valid), 512'(1'b0));
                assert (start_transfer === 1'b0)
                    else report_mismatch("start_transfer", 512'(start_transfer), 512'(1'b0));
            end
        end
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        fail_run("Timeout: the frames did not complete within the expected time");
    end

endmodule

//--- project.f
cm_pkg.sv
udp_hdr_filter.sv
record_assembler.sv
qp_record_decoder.sv
cm_rx_top.sv
tb_clock.sv
cm_rx_tb.sv

//--- Makefile
TOP = cm_rx_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
